/* Bender.yml */
package:
  name: road_crosser

sources:
  - road_pkg.sv
  - rate_divider.sv
  - car_mover.sv
  - player_mover.sv
  - game_memory.sv
  - game_master.sv
  - road_crosser.sv
  - target: simulation
    files:
      - tb_road_crosser.sv

/* car_mover.sv */
// Moves every visible car one column to the right per tick, wrapping back to column 0.
// The new array is offered to the game memory with a one-cycle load strobe.
`timescale 1ns/100ps
`default_nettype none

module car_mover
    import road_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       game_active,
    input  logic       tick,
    input  car_array_t cars,
    output car_array_t cars_next,
    output logic       load_cars
);

    mover_state_e state;
    mover_state_e state_next;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            state <= MOVE_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            MOVE_IDLE:
                if (game_active)
                    state_next = MOVE_WAIT_TICK;
            MOVE_WAIT_TICK:
                if (!game_active)
                    state_next = MOVE_IDLE;
                else if (tick)
                    state_next = MOVE_UPDATE;
            MOVE_UPDATE:
                state_next = game_active ? MOVE_WAIT_TICK : MOVE_IDLE;
            default:
                state_next = MOVE_IDLE;
        endcase
    end

    // Colour 0 marks an empty slot, which stays where it is
    always_comb
    begin
        cars_next = cars;
        for (int i = 0; i < CAR_COUNT; i++)
        begin
            if (cars[i].colour != BLACK)
                cars_next[i].x = (cars[i].x == MAX_X) ? '0 : cars[i].x + 1'b1;
        end
    end

    assign load_cars = (state == MOVE_UPDATE) && game_active;

    // Load follows its tick by exactly one cycle
    assert property (@(posedge clock) disable iff (!rst_n)
        load_cars |-> game_active && $past(tick));

endmodule

`default_nettype wire

/* flist.f */
road_pkg.sv
rate_divider.sv
car_mover.sv
player_mover.sv
game_memory.sv
game_master.sv
road_crosser.sv
tb_road_crosser.sv

/* game_master.sv */
// Main game controller. Clears the screen, takes lives and car count from the switches,
// then runs frames: erase, draw, score, collision and win checks. Pixels leave on plot.
`timescale 1ns/100ps
`default_nettype none

module game_master
    import road_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       go,
    input  lives_t     switches,
    input  car_array_t cars,
    input  sprite_t    player,
    input  lives_t     lives,
    output logic       load_lives,
    output logic       load_count,
    output logic       init_game,
    output logic       load_score,
    output logic       player_home,
    output logic       lose_life,
    output score_t     new_score,
    output sprite_t    pixel,
    output logic       plot,
    output logic       game_active,
    output logic       game_won
);

    master_state_e state;
    coord_x_t      clr_x;
    coord_y_t      clr_y;
    car_idx_t      car_idx;
    logic          last_car;
    logic          hit;
    logic          emit;
    sprite_t       emit_pixel;

    // Frame being drawn, and what the previous frame left on screen
    car_array_t snap_cars;
    car_array_t drawn_cars;
    sprite_t    snap_player;
    sprite_t    drawn_player;

    assign last_car = car_idx == car_idx_t'(CAR_COUNT - 1);

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < CAR_COUNT; i++)
        begin
            if (snap_cars[i].colour != BLACK && snap_cars[i].x == snap_player.x &&
                snap_cars[i].y == snap_player.y)
                hit = 1'b1;
        end
    end

    assign load_lives  = (state == S_LIVES_RELEASE) && !go;
    assign load_count  = (state == S_COUNT_RELEASE) && !go;
    assign init_game   = state == S_INIT;
    assign load_score  = state == S_DRAW_PLAYER;
    assign lose_life   = (state == S_COLLIDE) && hit;
    assign player_home = lose_life;
    assign new_score   = score_t'(MAX_Y) - score_t'(snap_player.y);

    // Pixel for this cycle, registered onto the output below
    always_comb
    begin
        emit       = 1'b0;
        emit_pixel = '{x: clr_x, y: clr_y, colour: BLACK};
        case (state)
            S_CLEAR:
                emit = 1'b1;
            S_ERASE_CARS:
            begin
                emit              = drawn_cars[car_idx].colour != BLACK;
                emit_pixel        = drawn_cars[car_idx];
                emit_pixel.colour = BLACK;
            end
            S_ERASE_PLAYER:
            begin
                emit              = 1'b1;
                emit_pixel        = drawn_player;
                emit_pixel.colour = BLACK;
            end
            S_DRAW_CARS:
            begin
                emit       = snap_cars[car_idx].colour != BLACK;
                emit_pixel = snap_cars[car_idx];
            end
            S_DRAW_PLAYER:
            begin
                emit       = 1'b1;
                emit_pixel = snap_player;
            end
            default:
                emit = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= S_CLEAR;
            clr_x       <= '0;
            clr_y       <= '0;
            car_idx     <= '0;
            plot        <= 1'b0;
            game_active <= 1'b0;
            game_won    <= 1'b0;
        end
        else
        begin
            plot     <= emit;
            game_won <= 1'b0;
            case (state)
                // Raster scan, counters end back at zero for the next clear
                S_CLEAR:
                begin
                    if (clr_x == MAX_X)
                    begin
                        clr_x <= '0;
                        if (clr_y == MAX_Y)
                        begin
                            clr_y <= '0;
                            state <= S_LIVES_PRESS;
                        end
                        else
                            clr_y <= clr_y + 1'b1;
                    end
                    else
                        clr_x <= clr_x + 1'b1;
                end
                S_LIVES_PRESS:
                    if (go)
                        state <= S_LIVES_RELEASE;
                S_LIVES_RELEASE:
                    if (!go)
                        state <= S_COUNT_PRESS;
                S_COUNT_PRESS:
                    if (go)
                        state <= S_COUNT_RELEASE;
                S_COUNT_RELEASE:
                    if (!go)
                        state <= S_INIT;
                S_INIT:
                begin
                    game_active <= 1'b1;
                    state       <= S_FRAME;
                end
                S_FRAME:
                    state <= S_ERASE_CARS;
                // Index wraps to zero on its own after the last slot
                S_ERASE_CARS:
                begin
                    car_idx <= car_idx + 1'b1;
                    if (last_car)
                        state <= S_ERASE_PLAYER;
                end
                S_ERASE_PLAYER:
                    state <= S_DRAW_CARS;
                S_DRAW_CARS:
                begin
                    car_idx <= car_idx + 1'b1;
                    if (last_car)
                        state <= S_DRAW_PLAYER;
                end
                S_DRAW_PLAYER:
                    state <= S_COLLIDE;
                S_COLLIDE:
                    state <= S_CHECK;
                // Lives already reflect a hit from the previous cycle
                S_CHECK:
                begin
                    if (lives == '0)
                    begin
                        game_active <= 1'b0;
                        state       <= S_CLEAR;
                    end
                    else if (snap_player.y == '0)
                    begin
                        game_won    <= 1'b1;
                        game_active <= 1'b0;
                        state       <= S_CLEAR;
                    end
                    else
                        state <= S_FRAME;
                end
                default:
                    state <= S_CLEAR;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        pixel <= emit_pixel;
        if (state == S_INIT)
        begin
            drawn_cars   <= '0;
            drawn_player <= PLAYER_HOME;
        end
        else if (state == S_FRAME)
        begin
            snap_cars   <= cars;
            snap_player <= player;
        end
        else if (state == S_DRAW_PLAYER)
        begin
            drawn_cars   <= snap_cars;
            drawn_player <= snap_player;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        plot |-> pixel.x <= MAX_X && pixel.y <= MAX_Y);

    // Car lanes stay clear of the safe zone
    assert property (@(posedge clock) disable iff (!rst_n)
        plot && pixel.colour != BLACK && pixel.colour != PLAYER_COLOUR |-> pixel.y < SAFE_Y_MIN);

    assert property (@(posedge clock) disable iff (!rst_n)
        load_lives |=> lives == (($past(switches) == '0) ? lives_t'(1) : $past(switches)));

endmodule

`default_nettype wire

/* game_memory.sv */
// Game state store: car array, player, lives, score and car count.
// Every load strobe takes effect on the next clock edge.
`timescale 1ns/100ps
`default_nettype none

module game_memory
    import road_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       load_lives,
    input  logic       load_count,
    input  logic       init_game,
    input  logic       load_score,
    input  logic       player_home,
    input  logic       lose_life,
    input  logic       load_cars,
    input  logic       load_player,
    input  lives_t     switch_value,
    input  car_array_t cars_next,
    input  sprite_t    player_next,
    input  score_t     new_score,
    output car_array_t cars,
    output sprite_t    player,
    output lives_t     lives,
    output score_t     score,
    output car_count_t car_count
);

    // One car per lane, staggered columns, only the first count of them visible
    function automatic car_array_t start_cars(car_count_t count);
        car_array_t layout;
        for (int i = 0; i < CAR_COUNT; i++)
        begin
            layout[i].x = coord_x_t'(int'(CAR_X_STEP) * i);
            layout[i].y = coord_y_t'(int'(CAR_LANE_BASE) + int'(CAR_LANE_STEP) * i);
            layout[i].colour = (i < int'(count)) ? colour_t'(1 + i % 6) : BLACK;
        end
        return layout;
    endfunction

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lives     <= '0;
            score     <= '0;
            car_count <= '0;
        end
        else
        begin
            // Zero lives on the switches would end the game at once
            if (load_lives)
                lives <= (switch_value == '0) ? lives_t'(1) : switch_value;
            else if (lose_life && lives != '0)
                lives <= lives - 1'b1;

            if (load_count)
            begin
                if (switch_value > lives_t'(CAR_COUNT))
                    car_count <= car_count_t'(CAR_COUNT);
                else
                    car_count <= car_count_t'(switch_value);
            end

            if (init_game)
                score <= '0;
            else if (load_score)
                score <= new_score;
        end
    end

    always_ff @(posedge clock)
    begin
        if (init_game)
            cars <= start_cars(car_count);
        else if (load_cars)
            cars <= cars_next;

        // Home position wins over a step taken in the same cycle
        if (init_game || player_home)
            player <= PLAYER_HOME;
        else if (load_player)
            player <= player_next;
    end

endmodule

`default_nettype wire

/* player_mover.sv */
// Steps the player one pixel per tick from the held direction key.
// Up wins over down, down over left, left over right; edge moves are dropped.
`timescale 1ns/100ps
`default_nettype none

module player_mover
    import road_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       game_active,
    input  logic       tick,
    input  move_keys_t keys,
    input  sprite_t    player,
    output sprite_t    player_next,
    output logic       load_player
);

    mover_state_e state;
    mover_state_e state_next;
    logic         move_ok;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            state <= MOVE_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            MOVE_IDLE:
                if (game_active)
                    state_next = MOVE_WAIT_TICK;
            MOVE_WAIT_TICK:
                if (!game_active)
                    state_next = MOVE_IDLE;
                else if (tick)
                    state_next = MOVE_UPDATE;
            MOVE_UPDATE:
                state_next = game_active ? MOVE_WAIT_TICK : MOVE_IDLE;
            default:
                state_next = MOVE_IDLE;
        endcase
    end

    always_comb
    begin
        player_next = player;
        move_ok     = 1'b0;
        if (!keys.up)
        begin
            move_ok       = player.y != '0;
            player_next.y = player.y - 1'b1;
        end
        else if (!keys.down)
        begin
            move_ok       = player.y != MAX_Y;
            player_next.y = player.y + 1'b1;
        end
        else if (!keys.left)
        begin
            move_ok       = player.x != '0;
            player_next.x = player.x - 1'b1;
        end
        else if (!keys.right)
        begin
            move_ok       = player.x != MAX_X;
            player_next.x = player.x + 1'b1;
        end
    end

    assign load_player = (state == MOVE_UPDATE) && game_active && move_ok;

    // A step lands in memory unless a collision sent the player home
    assert property (@(posedge clock) disable iff (!rst_n)
        load_player |=> (player == $past(player_next)) || (player == PLAYER_HOME));

endmodule

`default_nettype wire

/* rate_divider.sv */
// Movement pace generator. Pulses tick for one cycle every TICK_PERIOD clocks while
// enabled, and starts counting again from zero whenever enable drops.
`timescale 1ns/100ps
`default_nettype none

module rate_divider
    import road_pkg::*;
#(
    parameter int TICK_PERIOD = TICK_PERIOD_DEFAULT
) (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    output logic tick
);

    localparam int COUNT_W = $clog2(TICK_PERIOD);

    logic [COUNT_W-1:0] count;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (!enable)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == COUNT_W'(TICK_PERIOD - 1))
        begin
            count <= '0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) tick |=> !tick);

endmodule

`default_nettype wire

/* road_crosser.sv */
// Road-crossing game top level. Connects the controller, game memory, both movers
// and the pace divider; pixels leave as a plot strobe with a sprite.
`timescale 1ns/100ps
`default_nettype none

module road_crosser
    import road_pkg::*;
#(
    parameter int TICK_PERIOD = TICK_PERIOD_DEFAULT
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       go,
    input  lives_t     switches,
    input  move_keys_t keys,
    output sprite_t    pixel,
    output logic       plot,
    output logic       game_active,
    output logic       game_won,
    output lives_t     lives,
    output score_t     score
);

    logic       load_lives;
    logic       load_count;
    logic       init_game;
    logic       load_score;
    logic       player_home;
    logic       lose_life;
    logic       load_cars;
    logic       load_player;
    logic       tick;
    score_t     new_score;
    car_array_t cars;
    car_array_t cars_next;
    sprite_t    player;
    sprite_t    player_next;

    game_master u_master (
        .clock       (clock),
        .rst_n       (rst_n),
        .go          (go),
        .switches    (switches),
        .cars        (cars),
        .player      (player),
        .lives       (lives),
        .load_lives  (load_lives),
        .load_count  (load_count),
        .init_game   (init_game),
        .load_score  (load_score),
        .player_home (player_home),
        .lose_life   (lose_life),
        .new_score   (new_score),
        .pixel       (pixel),
        .plot        (plot),
        .game_active (game_active),
        .game_won    (game_won)
    );

    // Car count is only needed inside the memory for the start layout
    game_memory u_memory (
        .clock        (clock),
        .rst_n        (rst_n),
        .load_lives   (load_lives),
        .load_count   (load_count),
        .init_game    (init_game),
        .load_score   (load_score),
        .player_home  (player_home),
        .lose_life    (lose_life),
        .load_cars    (load_cars),
        .load_player  (load_player),
        .switch_value (switches),
        .cars_next    (cars_next),
        .player_next  (player_next),
        .new_score    (new_score),
        .cars         (cars),
        .player       (player),
        .lives        (lives),
        .score        (score),
        .car_count    ()
    );

    rate_divider #(
        .TICK_PERIOD (TICK_PERIOD)
    ) u_divider (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (game_active),
        .tick   (tick)
    );

    car_mover u_cars (
        .clock       (clock),
        .rst_n       (rst_n),
        .game_active (game_active),
        .tick        (tick),
        .cars        (cars),
        .cars_next   (cars_next),
        .load_cars   (load_cars)
    );

    player_mover u_player (
        .clock       (clock),
        .rst_n       (rst_n),
        .game_active (game_active),
        .tick        (tick),
        .keys        (keys),
        .player      (player),
        .player_next (player_next),
        .load_player (load_player)
    );

endmodule

`default_nettype wire

/* road_pkg.sv */
// Shared constants, vector types, sprite structs and FSM states of the road-crossing game.
// Every RTL file pulls this in with a wildcard import in its module header.
`default_nettype none

package road_pkg;

    // Car slots and default movement pace
    localparam int CAR_COUNT           = 8;
    localparam int TICK_PERIOD_DEFAULT = 2_500_000;

    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [2:0] colour_t;
    typedef logic [3:0] lives_t;
    typedef logic [7:0] score_t;
    typedef logic [3:0] car_count_t;
    typedef logic [$clog2(CAR_COUNT)-1:0] car_idx_t;

    // Screen is 160 x 120, bottom rows are the safe zone
    localparam coord_x_t MAX_X      = 8'd159;
    localparam coord_y_t MAX_Y      = 7'd119;
    localparam coord_y_t SAFE_Y_MIN = 7'd100;

    // Start layout of the cars
    localparam coord_y_t CAR_LANE_BASE = 7'd11;
    localparam coord_y_t CAR_LANE_STEP = 7'd12;
    localparam coord_x_t CAR_X_STEP    = 8'd20;

    localparam coord_x_t PLAYER_START_X = 8'd80;
    localparam colour_t  PLAYER_COLOUR  = 3'd7;
    localparam colour_t  BLACK          = 3'd0;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        colour_t  colour;
    } sprite_t;

    typedef sprite_t [CAR_COUNT-1:0] car_array_t;

    // Direction keys, active low like the board buttons
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } move_keys_t;

    localparam sprite_t PLAYER_HOME = '{x: PLAYER_START_X, y: MAX_Y, colour: PLAYER_COLOUR};

    typedef enum logic [3:0] {
        S_CLEAR,
        S_LIVES_PRESS,
        S_LIVES_RELEASE,
        S_COUNT_PRESS,
        S_COUNT_RELEASE,
        S_INIT,
        S_FRAME,
        S_ERASE_CARS,
        S_ERASE_PLAYER,
        S_DRAW_CARS,
        S_DRAW_PLAYER,
        S_COLLIDE,
        S_CHECK
    } master_state_e;

    typedef enum logic [1:0] {
        MOVE_IDLE,
        MOVE_WAIT_TICK,
        MOVE_UPDATE
    } mover_state_e;

endpackage

`default_nettype wire

/* tb_road_crosser.sv */
// Self-checking testbench for the road-crossing game top level.
// Applies a table of game setups, watches the pixel stream and checks frames and outcomes.
`timescale 1ns/100ps
`default_nettype none

module tb_road_crosser
    import road_pkg::*;
();

    localparam int TICK_PERIOD   = 64;
    localparam int RESET_CYCLES  = 16;
    localparam int CLEAR_PIXELS  = 19200;
    localparam int CLEAR_TIMEOUT = CLEAR_PIXELS + 200;
    localparam int FRAME_TIMEOUT = 100;
    localparam int MAX_FRAMES    = 1000;
    localparam int RUN_FRAMES    = 6;
    localparam int NUM_ROWS      = 5;

    localparam move_keys_t KEYS_IDLE = '{up: 1'b1, down: 1'b1, left: 1'b1, right: 1'b1};
    localparam move_keys_t KEYS_UP   = '{up: 1'b0, down: 1'b1, left: 1'b1, right: 1'b1};

    typedef enum logic [1:0] {KEY_NONE, KEY_UP, KEY_UP_TO_95} key_action_e;
    typedef enum logic [1:0] {RES_RUN, RES_WIN, RES_LOSE} result_e;

    typedef struct packed {
        lives_t      lives_sw;
        lives_t      cars_sw;
        key_action_e action;
        result_e     result;
    } table_row_t;

    logic       clock = 1'b0;
    logic       rst_n;
    logic       go;
    lives_t     switches;
    move_keys_t keys;
    sprite_t    pixel;
    logic       plot;
    logic       game_active;
    logic       game_won;
    lives_t     lives;
    score_t     score;

    table_row_t rows [NUM_ROWS];
    string      row_names [NUM_ROWS];

    // Values sampled on the falling edge
    logic   s_plot = 1'b0;
    logic   s_active = 1'b0;
    logic   s_won = 1'b0;
    lives_t s_lives = '0;
    score_t s_score = '0;
    logic   prev_active = 1'b0;
    int     clear_idx = 0;
    int     won_cnt = 0;
    int     fall_cnt = 0;
    logic   fall_won = 1'b0;
    int     frame_cnt = 0;
    int     frame_px = 0;
    int     frame_py = 0;
    int     frame_cars = 0;
    int     car_pix = 0;

    // Test bookkeeping
    string  cur_name = "reset";
    int     exp_cars = 0;
    int     seen_frames = 0;
    int     err_cnt = 0;
    int     row_err = 0;
    int     rows_passed = 0;
    int     rows_failed = 0;
    int     row_idx;
    int     seed_value;
    logic   timed_out = 1'b0;

    road_crosser #(
        .TICK_PERIOD (TICK_PERIOD)
    ) DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .go          (go),
        .switches    (switches),
        .keys        (keys),
        .pixel       (pixel),
        .plot        (plot),
        .game_active (game_active),
        .game_won    (game_won),
        .lives       (lives),
        .score       (score)
    );

    initial
    begin
        forever
        begin
            #10 clock = ~clock;
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("Fail %s, %s: expected %0d, actual %0d", cur_name, what, expected, actual);
            err_cnt++;
            row_err++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", cur_name, what);
        err_cnt++;
        row_err++;
        timed_out = 1'b1;
    endtask

    // Clear runs in raster order, row by row
    task automatic check_clear_pixel(input sprite_t p);
        sprite_t expected;
        expected.x      = coord_x_t'(clear_idx % 160);
        expected.y      = coord_y_t'(clear_idx / 160);
        expected.colour = BLACK;
        check_value("clear pixel", expected, p);
        clear_idx++;
    endtask

    // Car i sits on row 11 + 12 * i with colour 1 + i mod 6
    task automatic check_car_pixel(input sprite_t p);
        int   lane;
        int   idx;
        logic on_lane;
        lane    = int'(p.y) - int'(CAR_LANE_BASE);
        on_lane = (lane >= 0) && (lane % int'(CAR_LANE_STEP) == 0);
        car_pix++;
        check_value("car on a lane", 1, on_lane);
        check_value("car outside safe rows", 1, p.y < SAFE_Y_MIN);
        if (on_lane)
        begin
            idx = lane / int'(CAR_LANE_STEP);
            check_value("car slot active", 1, idx < exp_cars);
            check_value("car colour", 1 + idx % 6, p.colour);
        end
    endtask

    // Player pixel closes a frame
    task automatic record_player(input sprite_t p);
        check_value("score", int'(MAX_Y) - int'(p.y), score);
        frame_px   = p.x;
        frame_py   = p.y;
        frame_cars = car_pix;
        car_pix    = 0;
        frame_cnt++;
    endtask

    always @(negedge clock)
    begin
        s_plot   = plot;
        s_active = game_active;
        s_won    = game_won;
        s_lives  = lives;
        s_score  = score;
        if (!rst_n)
        begin
            clear_idx = 0;
            car_pix   = 0;
        end
        else
        begin
            if (prev_active && !game_active)
            begin
                fall_cnt++;
                fall_won = game_won;
            end
            if (game_won)
                won_cnt++;
            if (game_active)
                clear_idx = 0;
            if (plot)
            begin
                if (!game_active)
                    check_clear_pixel(pixel);
                else if (pixel.colour == PLAYER_COLOUR)
                    record_player(pixel);
                else if (pixel.colour != BLACK)
                    check_car_pixel(pixel);
            end
        end
        prev_active = game_active;
    end

    task automatic fill_table();
        rows[0]      = '{lives_sw: lives_t'($urandom % 16), cars_sw: lives_t'($urandom % 16),
                         action: KEY_NONE, result: RES_RUN};
        row_names[0] = "random_setup";
        rows[1]      = '{lives_sw: 4'd0, cars_sw: 4'd12, action: KEY_NONE, result: RES_RUN};
        row_names[1] = "zero_lives_many_cars";
        rows[2]      = '{lives_sw: 4'd3, cars_sw: 4'd5, action: KEY_NONE, result: RES_RUN};
        row_names[2] = "five_cars";
        rows[3]      = '{lives_sw: 4'd2, cars_sw: 4'd0, action: KEY_UP, result: RES_WIN};
        row_names[3] = "climb_to_win";
        rows[4]      = '{lives_sw: 4'd1, cars_sw: 4'd8, action: KEY_UP_TO_95, result: RES_LOSE};
        row_names[4] = "hit_on_last_life";
    endtask

    task automatic apply_reset();
        @(posedge clock);
        rst_n <= 1'b0;
        go    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        check_value("plot in reset", 0, s_plot);
        check_value("game_active in reset", 0, s_active);
        check_value("game_won in reset", 0, s_won);
        rst_n <= 1'b1;
    endtask

    // Waits for a full-screen clear, then makes sure nothing more is plotted
    task automatic wait_clear();
        int waited;
        waited = 0;
        while (clear_idx < CLEAR_PIXELS && waited < CLEAR_TIMEOUT)
        begin
            @(posedge clock);
            waited++;
        end
        if (clear_idx < CLEAR_PIXELS)
        begin
            report_timeout("screen clear did not finish");
            return;
        end
        repeat (20) @(posedge clock);
        check_value("clear pixel count", CLEAR_PIXELS, clear_idx);
        check_value("game_active after clear", 0, s_active);
    endtask

    task automatic press_go(input lives_t value);
        switches <= value;
        repeat (2) @(posedge clock);
        go <= 1'b1;
        repeat (3) @(posedge clock);
        go <= 1'b0;
        repeat (3) @(posedge clock);
    endtask

    task automatic wait_active();
        int waited;
        waited = 0;
        while (!s_active && waited < 20)
        begin
            @(posedge clock);
            waited++;
        end
        if (!s_active)
            report_timeout("game_active did not rise after setup");
    endtask

    // Returns with got low when the game ends instead
    task automatic next_frame(output logic got);
        int waited;
        waited = 0;
        got    = 1'b0;
        while (frame_cnt == seen_frames && s_active && waited < FRAME_TIMEOUT)
        begin
            @(posedge clock);
            waited++;
        end
        if (frame_cnt != seen_frames)
        begin
            seen_frames = frame_cnt;
            got         = 1'b1;
        end
        else if (s_active)
            report_timeout("no frame was drawn");
    endtask

    task automatic run_row(input int i);
        table_row_t row;
        int         expect_lives;
        int         frames;
        int         start_won;
        int         start_fall;
        int         last_py;
        logic       got;
        row          = rows[i];
        cur_name     = row_names[i];
        row_err      = 0;
        exp_cars     = (int'(row.cars_sw) > CAR_COUNT) ? CAR_COUNT : int'(row.cars_sw);
        expect_lives = (row.lives_sw == '0) ? 1 : int'(row.lives_sw);
        keys        <= (row.action == KEY_NONE) ? KEYS_IDLE : KEYS_UP;
        apply_reset();
        wait_clear();
        if (timed_out)
            return;
        press_go(row.lives_sw);
        press_go(row.cars_sw);
        wait_active();
        if (timed_out)
            return;
        check_value("lives at start", expect_lives, s_lives);
        check_value("score at start", 0, s_score);
        start_won  = won_cnt;
        start_fall = fall_cnt;

        // First frame shows the player at home
        next_frame(got);
        if (timed_out)
            return;
        check_value("first frame drawn", 1, got);
        check_value("player start column", PLAYER_START_X, frame_px);
        check_value("player start row", MAX_Y, frame_py);
        check_value("car pixels per frame", exp_cars, frame_cars);
        last_py = frame_py;
        frames  = 1;

        if (row.result == RES_RUN)
        begin
            while (frames < RUN_FRAMES)
            begin
                next_frame(got);
                if (timed_out)
                    return;
                frames++;
                check_value("frame drawn", 1, got);
                check_value("player column", PLAYER_START_X, frame_px);
                check_value("player row", MAX_Y, frame_py);
                check_value("car pixels per frame", exp_cars, frame_cars);
            end
            return;
        end

        while (got && frames < MAX_FRAMES)
        begin
            next_frame(got);
            if (timed_out)
                return;
            if (got)
            begin
                frames++;
                check_value("car pixels per frame", exp_cars, frame_cars);
                check_value("player row never rises", 1, frame_py <= last_py);
                last_py = frame_py;
                if (row.action == KEY_UP_TO_95 && frame_py == 95)
                    keys <= KEYS_IDLE;
            end
        end
        if (got)
        begin
            $display("Error in %s: game did not end after %0d frames", cur_name, frames);
            err_cnt++;
            row_err++;
            return;
        end

        check_value("game_active falls", 1, fall_cnt - start_fall);
        check_value("game_won pulses", (row.result == RES_WIN) ? 1 : 0, won_cnt - start_won);
        check_value("game_won with the fall", (row.result == RES_WIN) ? 1 : 0, fall_won);
        check_value("last player row", (row.result == RES_WIN) ? 0 : 95, last_py);
        check_value("lives at end", (row.result == RES_WIN) ? expect_lives : 0, s_lives);
        wait_clear();
    endtask

    initial
    begin
        rst_n    = 1'b0;
        go       = 1'b0;
        switches = '0;
        keys     = KEYS_IDLE;
        seed_value = $urandom(57139);
        fill_table();

        for (row_idx = 0; row_idx < NUM_ROWS && !timed_out; row_idx++)
        begin
            run_row(row_idx);
            if (row_err == 0)
            begin
                rows_passed++;
                $display("Test %s passed", cur_name);
            end
            else
            begin
                rows_failed++;
                $display("Test %s failed with %0d errors", cur_name, row_err);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 rows_passed + rows_failed, rows_passed, rows_failed, err_cnt);
        if (err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
